// ==== rtl/versat_macros.svh ====
`ifndef VERSAT_MACROS_SVH
`define VERSAT_MACROS_SVH

// cpu side register window, byte address
`define VERSAT_ADDR_W 5

// data word on both the cpu and memory side
`define VERSAT_DATA_W 32

// memory byte address
`define VERSAT_MEM_ADDR_W 16

// burst length in words, zero means nothing to do
`define VERSAT_LEN_W 8

// word registers behind the IOb slave
`define VERSAT_N_REGS 8

`endif

// ==== rtl/versat_cfg_pkg.sv ====
`include "versat_macros.svh"

package versat_cfg_pkg;

   localparam int REG_IDX_W = $clog2(`VERSAT_N_REGS);

   // word registers, index comes from address bits 4:2
   typedef enum logic [REG_IDX_W-1:0] {
      REG_CTRL     = 0,
      REG_STATUS   = 1,
      REG_RD_ADDR  = 2,
      REG_RD_LEN   = 3,
      REG_WR_ADDR  = 4,
      REG_WR_LEN   = 5,
      REG_WR_VALUE = 6,
      REG_SUM      = 7
   } reg_idx_t;

   // start bits in REG_CTRL, busy bits in REG_STATUS
   localparam int CTRL_RD_START = 0;
   localparam int CTRL_WR_START = 1;

endpackage

// ==== rtl/versat_bus_pkg.sv ====
`include "versat_macros.svh"

package versat_bus_pkg;

   typedef logic [`VERSAT_DATA_W-1:0] word_t;
   typedef logic [`VERSAT_MEM_ADDR_W-1:0] mem_addr_t;
   typedef logic [`VERSAT_LEN_W-1:0] len_t;

   // index of a data mover on the merged memory port
   typedef logic master_t;

   localparam master_t MST_RD = 1'b0;
   localparam master_t MST_WR = 1'b1;

endpackage

// ==== rtl/versat_csr.sv ====
`include "versat_macros.svh"

module versat_csr (
   input  logic                          clk_i,
   input  logic                          rst_n_i,
   input  logic                          iob_valid_i,
   input  logic [    `VERSAT_ADDR_W-1:0] iob_addr_i,
   input  versat_bus_pkg::word_t         iob_wdata_i,
   input  logic [`VERSAT_DATA_W/8-1:0]   iob_wstrb_i,
   output logic                          iob_rvalid_o,
   output versat_bus_pkg::word_t         iob_rdata_o,
   output logic                          rd_start_o,
   output versat_bus_pkg::mem_addr_t     rd_addr_o,
   output versat_bus_pkg::len_t          rd_len_o,
   output logic                          wr_start_o,
   output versat_bus_pkg::mem_addr_t     wr_addr_o,
   output versat_bus_pkg::len_t          wr_len_o,
   output versat_bus_pkg::word_t         wr_value_o,
   input  logic                          rd_done_i,
   input  versat_bus_pkg::word_t         rd_sum_i,
   input  logic                          wr_done_i
);
   import versat_cfg_pkg::*;
   import versat_bus_pkg::*;

   reg_idx_t  idx;
   logic      wr_en;
   logic      rd_en;
   logic      ctrl_wr;
   logic      rd_go;
   logic      wr_go;
   logic      rd_busy_q;
   logic      wr_busy_q;
   logic      rd_start_q;
   logic      wr_start_q;
   mem_addr_t rd_addr_q;
   len_t      rd_len_q;
   mem_addr_t wr_addr_q;
   len_t      wr_len_q;
   word_t     wr_value_q;
   logic      rvalid_q;
   word_t     rdata_d;
   word_t     rdata_q;

   assign idx   = reg_idx_t'(iob_addr_i[`VERSAT_ADDR_W-1:2]);
   assign wr_en = iob_valid_i & (|iob_wstrb_i);
   assign rd_en = iob_valid_i & ~(|iob_wstrb_i);

   // a start for a unit that is still running is dropped
   assign ctrl_wr = wr_en & (idx == REG_CTRL);
   assign rd_go   = ctrl_wr & iob_wdata_i[CTRL_RD_START] & ~rd_busy_q;
   assign wr_go   = ctrl_wr & iob_wdata_i[CTRL_WR_START] & ~wr_busy_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_start_q <= 1'b0;
         wr_start_q <= 1'b0;
         rd_busy_q  <= 1'b0;
         wr_busy_q  <= 1'b0;
         rd_addr_q  <= '0;
         rd_len_q   <= '0;
         wr_addr_q  <= '0;
         wr_len_q   <= '0;
         wr_value_q <= '0;
         rvalid_q   <= 1'b0;
      end else begin
         rd_start_q <= rd_go;
         wr_start_q <= wr_go;
         rvalid_q   <= rd_en;
         // busy is raised with the start pulse, done drops it
         if (rd_go) begin
            rd_busy_q <= 1'b1;
         end else if (rd_done_i) begin
            rd_busy_q <= 1'b0;
         end
         if (wr_go) begin
            wr_busy_q <= 1'b1;
         end else if (wr_done_i) begin
            wr_busy_q <= 1'b0;
         end
         if (wr_en) begin
            case (idx)
               REG_RD_ADDR:  rd_addr_q  <= mem_addr_t'(iob_wdata_i);
               REG_RD_LEN:   rd_len_q   <= len_t'(iob_wdata_i);
               REG_WR_ADDR:  wr_addr_q  <= mem_addr_t'(iob_wdata_i);
               REG_WR_LEN:   wr_len_q   <= len_t'(iob_wdata_i);
               REG_WR_VALUE: wr_value_q <= iob_wdata_i;
               default: ;
            endcase
         end
      end
   end

   // readback mux, ctrl reads as zero since its bits are pulses
   always_comb begin
      rdata_d = '0;
      case (idx)
         REG_STATUS: begin
            rdata_d[CTRL_RD_START] = rd_busy_q;
            rdata_d[CTRL_WR_START] = wr_busy_q;
         end
         REG_RD_ADDR:  rdata_d = word_t'(rd_addr_q);
         REG_RD_LEN:   rdata_d = word_t'(rd_len_q);
         REG_WR_ADDR:  rdata_d = word_t'(wr_addr_q);
         REG_WR_LEN:   rdata_d = word_t'(wr_len_q);
         REG_WR_VALUE: rdata_d = wr_value_q;
         REG_SUM:      rdata_d = rd_sum_i;
         default: ;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         rdata_q <= rdata_d;
      end
   end

   assign iob_rvalid_o = rvalid_q;
   assign iob_rdata_o  = rdata_q;
   assign rd_start_o   = rd_start_q;
   assign rd_addr_o    = rd_addr_q;
   assign rd_len_o     = rd_len_q;
   assign wr_start_o   = wr_start_q;
   assign wr_addr_o    = wr_addr_q;
   assign wr_len_o     = wr_len_q;
   assign wr_value_o   = wr_value_q;

endmodule

// ==== rtl/versat_vread.sv ====
module versat_vread (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  logic                      start_i,
   input  versat_bus_pkg::mem_addr_t addr_i,
   input  versat_bus_pkg::len_t      len_i,
   output logic                      valid_o,
   output versat_bus_pkg::mem_addr_t addr_o,
   output versat_bus_pkg::len_t      len_o,
   input  logic                      ready_i,
   input  logic                      last_i,
   input  versat_bus_pkg::word_t     rdata_i,
   output logic                      done_o,
   output versat_bus_pkg::word_t     sum_o
);
   import versat_bus_pkg::*;

   logic      valid_q;
   logic      zero_q;
   mem_addr_t addr_q;
   len_t      len_q;
   word_t     sum_q;
   logic      beat;
   logic      last_beat;

   assign beat      = valid_q & ready_i;
   assign last_beat = beat & last_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
         zero_q  <= 1'b0;
         sum_q   <= '0;
      end else begin
         // empty burst, finish on the next cycle without a request
         zero_q <= start_i & (len_i == '0);
         if (start_i) begin
            valid_q <= (len_i != '0);
            sum_q   <= '0;
         end else begin
            if (last_beat) begin
               valid_q <= 1'b0;
            end
            if (beat) begin
               sum_q <= sum_q + rdata_i;
            end
         end
      end
   end

   // base address only, the merge adds the beat offset
   always_ff @(posedge clk_i) begin
      if (start_i) begin
         addr_q <= addr_i;
         len_q  <= len_i;
      end
   end

   assign valid_o = valid_q;
   assign addr_o  = addr_q;
   assign len_o   = len_q;
   assign done_o  = last_beat | zero_q;
   assign sum_o   = sum_q;

endmodule

// ==== rtl/versat_vwrite.sv ====
module versat_vwrite (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  logic                      start_i,
   input  versat_bus_pkg::mem_addr_t addr_i,
   input  versat_bus_pkg::len_t      len_i,
   input  versat_bus_pkg::word_t     value_i,
   output logic                      valid_o,
   output versat_bus_pkg::mem_addr_t addr_o,
   output versat_bus_pkg::len_t      len_o,
   output versat_bus_pkg::word_t     wdata_o,
   input  logic                      ready_i,
   input  logic                      last_i,
   output logic                      done_o
);
   import versat_bus_pkg::*;

   logic      valid_q;
   logic      zero_q;
   mem_addr_t addr_q;
   len_t      len_q;
   word_t     pattern_q;
   logic      beat;
   logic      last_beat;

   assign beat      = valid_q & ready_i;
   assign last_beat = beat & last_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
         zero_q  <= 1'b0;
      end else begin
         zero_q <= start_i & (len_i == '0);
         if (start_i) begin
            valid_q <= (len_i != '0);
         end else if (last_beat) begin
            valid_q <= 1'b0;
         end
      end
   end

   // word k of the burst carries value + k
   always_ff @(posedge clk_i) begin
      if (start_i) begin
         addr_q    <= addr_i;
         len_q     <= len_i;
         pattern_q <= value_i;
      end else if (beat) begin
         pattern_q <= pattern_q + word_t'(1);
      end
   end

   assign valid_o = valid_q;
   assign addr_o  = addr_q;
   assign len_o   = len_q;
   assign wdata_o = pattern_q;
   assign done_o  = last_beat | zero_q;

endmodule

// ==== rtl/xmerge.sv ====
`include "versat_macros.svh"

module xmerge (
   input  logic                        clk_i,
   input  logic                        rst_n_i,
   input  logic [1:0]                  s_valid_i,
   input  versat_bus_pkg::mem_addr_t   s_addr_i   [2],
   input  versat_bus_pkg::len_t        s_len_i    [2],
   input  versat_bus_pkg::word_t       s_wdata_i,
   output logic [1:0]                  s_ready_o,
   output logic [1:0]                  s_last_o,
   output versat_bus_pkg::word_t       s_rdata_o,
   output logic                        mem_valid_o,
   output logic                        mem_we_o,
   output versat_bus_pkg::mem_addr_t   mem_addr_o,
   output versat_bus_pkg::word_t       mem_wdata_o,
   output logic [`VERSAT_DATA_W/8-1:0] mem_wstrb_o,
   input  logic                        mem_ready_i,
   input  versat_bus_pkg::word_t       mem_rdata_i
);
   import versat_bus_pkg::*;

   logic    busy_q;
   master_t owner_q;
   master_t prio_q;
   len_t    cnt_q;
   master_t pick;
   logic    beat;
   logic    final_beat;

   // prefer the master that did not own the previous burst
   assign pick = s_valid_i[prio_q] ? prio_q : ~prio_q;

   // granted path, purely combinational
   assign mem_valid_o = busy_q & s_valid_i[owner_q];
   assign mem_we_o    = busy_q & (owner_q == MST_WR);
   assign mem_addr_o  = s_addr_i[owner_q] + mem_addr_t'({cnt_q, 2'b00});
   assign mem_wdata_o = s_wdata_i;
   assign mem_wstrb_o = {(`VERSAT_DATA_W/8){mem_we_o}};

   assign beat       = mem_valid_o & mem_ready_i;
   assign final_beat = beat & (cnt_q == s_len_i[owner_q] - len_t'(1));

   // read data goes to everyone, only the owner sees ready
   assign s_rdata_o = mem_rdata_i;

   always_comb begin
      s_ready_o          = '0;
      s_last_o           = '0;
      s_ready_o[owner_q] = busy_q & mem_ready_i;
      s_last_o[owner_q]  = final_beat;
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy_q  <= 1'b0;
         owner_q <= MST_RD;
         prio_q  <= MST_RD;
         cnt_q   <= '0;
      end else if (!busy_q) begin
         // new grant only from idle
         if (|s_valid_i) begin
            busy_q  <= 1'b1;
            owner_q <= pick;
         end
      end else if (final_beat) begin
         busy_q <= 1'b0;
         cnt_q  <= '0;
         prio_q <= ~owner_q;
      end else if (beat) begin
         cnt_q <= cnt_q + len_t'(1);
      end
   end

endmodule

// ==== rtl/iob_versat.sv ====
`include "versat_macros.svh"

module iob_versat (
   input  logic                        clk_i,
   input  logic                        rst_n_i,
   input  logic                        iob_valid_i,
   input  logic [    `VERSAT_ADDR_W-1:0] iob_addr_i,
   input  versat_bus_pkg::word_t       iob_wdata_i,
   input  logic [`VERSAT_DATA_W/8-1:0] iob_wstrb_i,
   output logic                        iob_rvalid_o,
   output versat_bus_pkg::word_t       iob_rdata_o,
   output logic                        iob_ready_o,
   output logic                        mem_valid_o,
   output logic                        mem_we_o,
   output versat_bus_pkg::mem_addr_t   mem_addr_o,
   output versat_bus_pkg::word_t       mem_wdata_o,
   output logic [`VERSAT_DATA_W/8-1:0] mem_wstrb_o,
   input  logic                        mem_ready_i,
   input  versat_bus_pkg::word_t       mem_rdata_i
);
   import versat_bus_pkg::*;

   // configuration from the register file
   logic      rd_start;
   mem_addr_t rd_addr;
   len_t      rd_len;
   logic      wr_start;
   mem_addr_t wr_addr;
   len_t      wr_len;
   word_t     wr_value;
   logic      rd_done;
   logic      wr_done;
   word_t     rd_sum;

   // databus between movers and merge, index 0 reader, 1 writer
   logic [1:0] m_valid;
   logic [1:0] m_ready;
   logic [1:0] m_last;
   mem_addr_t  m_addr [2];
   len_t       m_len  [2];
   word_t      m_wdata;
   word_t      m_rdata;

   assign iob_ready_o = 1'b1;

   versat_csr csr (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .iob_valid_i (iob_valid_i),
      .iob_addr_i  (iob_addr_i),
      .iob_wdata_i (iob_wdata_i),
      .iob_wstrb_i (iob_wstrb_i),
      .iob_rvalid_o(iob_rvalid_o),
      .iob_rdata_o (iob_rdata_o),
      .rd_start_o  (rd_start),
      .rd_addr_o   (rd_addr),
      .rd_len_o    (rd_len),
      .wr_start_o  (wr_start),
      .wr_addr_o   (wr_addr),
      .wr_len_o    (wr_len),
      .wr_value_o  (wr_value),
      .rd_done_i   (rd_done),
      .rd_sum_i    (rd_sum),
      .wr_done_i   (wr_done)
   );

   versat_vread vread (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .start_i(rd_start),
      .addr_i (rd_addr),
      .len_i  (rd_len),
      .valid_o(m_valid[MST_RD]),
      .addr_o (m_addr[MST_RD]),
      .len_o  (m_len[MST_RD]),
      .ready_i(m_ready[MST_RD]),
      .last_i (m_last[MST_RD]),
      .rdata_i(m_rdata),
      .done_o (rd_done),
      .sum_o  (rd_sum)
   );

   versat_vwrite vwrite (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .start_i(wr_start),
      .addr_i (wr_addr),
      .len_i  (wr_len),
      .value_i(wr_value),
      .valid_o(m_valid[MST_WR]),
      .addr_o (m_addr[MST_WR]),
      .len_o  (m_len[MST_WR]),
      .wdata_o(m_wdata),
      .ready_i(m_ready[MST_WR]),
      .last_i (m_last[MST_WR]),
      .done_o (wr_done)
   );

   xmerge merge (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .s_valid_i  (m_valid),
      .s_addr_i   (m_addr),
      .s_len_i    (m_len),
      .s_wdata_i  (m_wdata),
      .s_ready_o  (m_ready),
      .s_last_o   (m_last),
      .s_rdata_o  (m_rdata),
      .mem_valid_o(mem_valid_o),
      .mem_we_o   (mem_we_o),
      .mem_addr_o (mem_addr_o),
      .mem_wdata_o(mem_wdata_o),
      .mem_wstrb_o(mem_wstrb_o),
      .mem_ready_i(mem_ready_i),
      .mem_rdata_i(mem_rdata_i)
   );

endmodule

// ==== testbench/iob_versat_asserts.sv ====
`include "versat_macros.svh"

module iob_versat_asserts (
   input logic                        clk_i,
   input logic                        rst_n_i,
   input logic                        iob_valid_i,
   input logic [`VERSAT_DATA_W/8-1:0] iob_wstrb_i,
   input logic                        iob_rvalid_o,
   input logic                        mem_valid_o,
   input logic                        mem_we_o,
   input versat_bus_pkg::mem_addr_t   mem_addr_o,
   input versat_bus_pkg::word_t       mem_wdata_o,
   input logic [`VERSAT_DATA_W/8-1:0] mem_wstrb_o,
   input logic                        mem_ready_i
);
   timeunit 1ns;
   timeprecision 1ps;

   logic rd_req;

   assign rd_req = iob_valid_i & ~(|iob_wstrb_i);

   // a stalled request keeps its address, direction and write data
   mem_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_we_o) &&
         $stable(mem_addr_o) && (!mem_we_o || $stable(mem_wdata_o)))
      else $error("memory request changed while stalled");

   rvalid_after_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rd_req |=> iob_rvalid_o)
      else $error("iob_rvalid_o missing one cycle after a read request");

   rvalid_needs_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      iob_rvalid_o |-> $past(rd_req))
      else $error("iob_rvalid_o without a read request in the previous cycle");

   wstrb_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mem_we_o |-> &mem_wstrb_o)
      else $error("mem_wstrb_o not all ones on a write");

endmodule

bind iob_versat iob_versat_asserts asserts (.*);

// ==== testbench/iob_versat_tb.sv ====
`include "versat_macros.svh"

module iob_versat_tb;
   timeunit 1ns;
   timeprecision 1ps;

   import versat_bus_pkg::*;
   import versat_cfg_pkg::*;

   typedef struct packed {
      mem_addr_t  rd_addr;
      len_t       rd_len;
      mem_addr_t  wr_addr;
      len_t       wr_len;
      word_t      wr_value;
      logic [1:0] start;
      logic       stall;
      logic       retry;
   } row_t;

   localparam int N_ROWS = 5;
   localparam int MEM_WORDS = 1024;

   logic                        clk_i;
   logic                        rst_n_i;
   logic                        iob_valid_i;
   logic [`VERSAT_ADDR_W-1:0]   iob_addr_i;
   word_t                       iob_wdata_i;
   logic [`VERSAT_DATA_W/8-1:0] iob_wstrb_i;
   logic                        iob_rvalid_o;
   word_t                       iob_rdata_o;
   logic                        iob_ready_o;
   logic                        mem_valid_o;
   logic                        mem_we_o;
   mem_addr_t                   mem_addr_o;
   word_t                       mem_wdata_o;
   logic [`VERSAT_DATA_W/8-1:0] mem_wstrb_o;
   logic                        mem_ready_i;
   word_t                       mem_rdata_i;

   word_t         mem [MEM_WORDS];
   word_t         ref_mem [MEM_WORDS];
   logic [1023:0] stall_pat;
   logic          stall_en;
   int unsigned   cyc = 0;
   row_t          rows [N_ROWS];

   iob_versat dut (.*);

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   // memory model, same-cycle read data
   assign mem_rdata_i = mem[mem_addr_o[11:2]];

   // byte lanes follow the write strobe
   always @(posedge clk_i) begin
      if (rst_n_i && mem_valid_o && mem_ready_i && mem_we_o) begin
         for (int b = 0; b < `VERSAT_DATA_W/8; b++) begin
            if (mem_wstrb_o[b]) begin
               mem[mem_addr_o[11:2]][b*8 +: 8] <= mem_wdata_o[b*8 +: 8];
            end
         end
      end
   end

   // ready follows a precomputed random pattern when stalls are on
   always @(negedge clk_i) begin
      cyc <= cyc + 1;
      mem_ready_i <= stall_en ? stall_pat[cyc % 1024] : 1'b1;
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         abort_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
      end
   endtask

   task automatic check_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
      if (got !== exp) begin
         abort_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
      end
   endtask

   task automatic check_status(input string name, input logic [1:0] got, input logic [1:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
      end
   endtask

   // all bus tasks start and end on a falling edge
   task automatic write_reg(input reg_idx_t idx, input word_t data);
      iob_valid_i = 1'b1;
      iob_addr_i  = {idx, 2'b00};
      iob_wdata_i = data;
      iob_wstrb_i = '1;
      @(negedge clk_i);
      iob_valid_i = 1'b0;
      iob_wstrb_i = '0;
   endtask

   task automatic read_reg(input reg_idx_t idx, output word_t data);
      iob_valid_i = 1'b1;
      iob_addr_i  = {idx, 2'b00};
      iob_wstrb_i = '0;
      @(negedge clk_i);
      iob_valid_i = 1'b0;
      if (iob_rvalid_o !== 1'b1) begin
         abort_run("iob_rvalid_o did not rise one cycle after a register read");
      end
      data = iob_rdata_o;
      @(negedge clk_i);
      if (iob_rvalid_o !== 1'b0) begin
         abort_run("iob_rvalid_o stayed high longer than one cycle");
      end
   endtask

   task automatic wait_idle();
      word_t data;
      int    polls;
      polls = 0;
      do begin
         read_reg(REG_STATUS, data);
         polls++;
      end while (data[1:0] != 2'b00 && polls < 2000);
      if (data[1:0] != 2'b00) begin
         abort_run("timeout, busy bits still set after 2000 status reads");
      end
   endtask

   task automatic compare_mem();
      for (int i = 0; i < MEM_WORDS; i++) begin
         check_word($sformatf("mem[%0d]", i), mem[i], ref_mem[i]);
      end
   endtask

   task automatic run_row(input row_t row);
      word_t data;
      word_t sum_exp;
      int    rd_base;
      int    wr_base;
      write_reg(REG_RD_ADDR, word_t'(row.rd_addr));
      write_reg(REG_RD_LEN, word_t'(row.rd_len));
      write_reg(REG_WR_ADDR, word_t'(row.wr_addr));
      write_reg(REG_WR_LEN, word_t'(row.wr_len));
      write_reg(REG_WR_VALUE, row.wr_value);
      read_reg(REG_RD_ADDR, data);
      check_addr("rd_addr", mem_addr_t'(data), row.rd_addr);
      read_reg(REG_RD_LEN, data);
      check_word("rd_len", data, word_t'(row.rd_len));
      read_reg(REG_WR_ADDR, data);
      check_addr("wr_addr", mem_addr_t'(data), row.wr_addr);
      read_reg(REG_WR_LEN, data);
      check_word("wr_len", data, word_t'(row.wr_len));
      read_reg(REG_WR_VALUE, data);
      check_word("wr_value", data, row.wr_value);
      // expected sum and pattern, ranges of one row never overlap
      sum_exp = '0;
      rd_base = int'(row.rd_addr) >> 2;
      wr_base = int'(row.wr_addr) >> 2;
      for (int k = 0; k < int'(row.rd_len); k++) begin
         sum_exp += ref_mem[rd_base + k];
      end
      if (row.start[CTRL_WR_START]) begin
         for (int k = 0; k < int'(row.wr_len); k++) begin
            ref_mem[wr_base + k] = row.wr_value + word_t'(k);
         end
      end
      stall_en <= row.stall;
      write_reg(REG_CTRL, word_t'(row.start));
      if (row.retry) begin
         read_reg(REG_STATUS, data);
         check_status("status busy", data[1:0] & row.start, row.start);
         // writer is busy, so the new address must never be used
         write_reg(REG_WR_ADDR, word_t'(16'h0c00));
         write_reg(REG_CTRL, word_t'(2'b10));
      end
      wait_idle();
      if (row.start[CTRL_RD_START]) begin
         read_reg(REG_SUM, data);
         check_word("sum", data, sum_exp);
      end
      compare_mem();
   endtask

   initial begin
      rst_n_i     = 1'b0;
      iob_valid_i = 1'b0;
      iob_addr_i  = '0;
      iob_wdata_i = '0;
      iob_wstrb_i = '0;
      mem_ready_i = 1'b1;
      stall_en    = 1'b0;
      void'($urandom(32'h27a3ac36));
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i]     = $urandom;
         ref_mem[i] = mem[i];
      end
      for (int i = 0; i < 32; i++) begin
         stall_pat[i*32 +: 32] = $urandom;
      end
      // rd_addr rd_len wr_addr wr_len wr_value start stall retry
      rows[0] = '{16'h0100, 8'd8, 16'h0400, 8'd6, 32'h1000_0000, 2'b01, 1'b0, 1'b0};
      rows[1] = '{16'h0100, 8'd8, 16'h0400, 8'd6, 32'hffff_fffe, 2'b10, 1'b0, 1'b0};
      rows[2] = '{16'h0200, 8'd20, 16'h0600, 8'd12, 32'h0000_abcd, 2'b11, 1'b1, 1'b0};
      rows[3] = '{16'h0300, 8'd0, 16'h0700, 8'd0, 32'h5555_0000, 2'b11, 1'b1, 1'b0};
      rows[4] = '{16'h0400, 8'd6, 16'h0800, 8'd255, 32'h7fff_ff80, 2'b11, 1'b1, 1'b1};
      repeat (10) @(negedge clk_i);
      rst_n_i = 1'b1;
      @(negedge clk_i);
      check_status("reset valids", {mem_valid_o, iob_rvalid_o}, 2'b00);
      check_status("iob_ready_o", {1'b0, iob_ready_o}, 2'b01);
      for (int r = 0; r < N_ROWS; r++) begin
         run_row(rows[r]);
      end
      $display("All tests passed!");
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+rtl
rtl/versat_cfg_pkg.sv
rtl/versat_bus_pkg.sv
rtl/versat_csr.sv
rtl/versat_vread.sv
rtl/versat_vwrite.sv
rtl/xmerge.sv
rtl/iob_versat.sv
testbench/iob_versat_asserts.sv
testbench/iob_versat_tb.sv
